// File: rtl/bramPkg.sv
package bramPkg;

  // Geometry of one RAM cell
  localparam int bramBits  = 32;            // Bits per cell word
  localparam int bramBytes = bramBits / 8;  // Byte lanes per cell word

  // Port byte address
  localparam int addrBits = 32;

  // Byte address as seen on ports A and B
  typedef logic [addrBits-1:0] addrT;

  // One cell's data word
  typedef logic [bramBits-1:0] cellWordT;

  // One cell's byte write enables, bit n covers bits 8n+7..8n
  typedef logic [bramBytes-1:0] cellBeT;

endpackage

// File: rtl/bramAddrDecode.sv
`timescale 1ns/1ps

module bramAddrDecode #(
  parameter int numParBrams  = 3,
  parameter int numSerBrams  = 4,
  parameter int wordsPerBram = 256
) (
  input  bramPkg::addrT addr,
  output logic [((numSerBrams > 1) ? $clog2(numSerBrams) : 1)-1:0] serIdx,
  output logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] wordIdx
);

  localparam int serBits  = (numSerBrams > 1) ? $clog2(numSerBrams) : 1;
  localparam int wordBits = (wordsPerBram > 1) ? $clog2(wordsPerBram) : 1;
  localparam int rowBits  = bramPkg::addrBits - 2;

  // Divisors at the width of the row arithmetic
  localparam logic [rowBits-1:0] parDiv  = rowBits'(numParBrams);
  localparam logic [rowBits-1:0] wordDiv = rowBits'(wordsPerBram);

  logic [rowBits-1:0] wordAddr;  // 32-bit word address
  logic [rowBits-1:0] rowIdx;    // Index of a full row of cells
  logic [rowBits-1:0] serFull;
  logic [rowBits-1:0] wordFull;

  assign wordAddr = addr[bramPkg::addrBits-1:2];  // Byte offset dropped
  assign rowIdx   = wordAddr / parDiv;

  // Stacked row and word inside each cell
  assign serFull  = rowIdx / wordDiv;
  assign wordFull = rowIdx % wordDiv;

  assign serIdx  = serFull[serBits-1:0];  // Range is checked outside the RTL
  assign wordIdx = wordFull[wordBits-1:0];

endmodule

// File: rtl/tdpBramCell.sv
`timescale 1ns/1ps

module tdpBramCell #(
  parameter int wordsPerBram = 256
) (
  input  logic               A_PS,
  input  logic               rstN,
  input  logic               enA,
  input  logic               enB,
  input  bramPkg::cellBeT    weA,
  input  bramPkg::cellBeT    weB,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] addrA,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] addrB,
  input  bramPkg::cellWordT  wrDataA,
  input  bramPkg::cellWordT  wrDataB,
  output bramPkg::cellWordT  rdDataA,
  output bramPkg::cellWordT  rdDataB
);

  bramPkg::cellWordT mem [wordsPerBram];

  bramPkg::cellWordT mergedA;  // Stored word with port A bytes applied
  bramPkg::cellWordT mergedB;

  // Byte merge of new data over the addressed word
  always_comb begin
    mergedA = mem[addrA];
    mergedB = mem[addrB];
    for (int b = 0; b < bramPkg::bramBytes; b++) begin
      if (weA[b]) mergedA[8*b +: 8] = wrDataA[8*b +: 8];
      if (weB[b]) mergedB[8*b +: 8] = wrDataB[8*b +: 8];
    end
  end

  // Array writes, same-word collisions between ports are undefined
  always_ff @(posedge A_PS) begin
    if (enA && (|weA)) mem[addrA] <= mergedA;
    if (enB && (|weB)) mem[addrB] <= mergedB;
  end

  // Write-first read registers, hold while disabled
  always_ff @(posedge A_PS or negedge rstN) begin
    if (!rstN) begin
      rdDataA <= '0;
      rdDataB <= '0;
    end else begin
      if (enA) rdDataA <= mergedA;
      if (enB) rdDataB <= mergedB;
    end
  end

endmodule

// File: rtl/bramBank.sv
`timescale 1ns/1ps

module bramBank #(
  parameter int numParBrams  = 3,
  parameter int numSerBrams  = 4,
  parameter int wordsPerBram = 256,
  parameter int bankIdx      = 0
) (
  input  logic A_PS,
  input  logic rstN,
  input  logic [((numSerBrams > 1) ? $clog2(numSerBrams) : 1)-1:0]   serIdxA,
  input  logic [((numSerBrams > 1) ? $clog2(numSerBrams) : 1)-1:0]   serIdxB,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] wordIdxA,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] wordIdxB,
  input  logic enA,
  input  logic enB,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weA,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weB,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataA,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataB,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataA,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataB
);

  localparam int serBits  = (numSerBrams > 1) ? $clog2(numSerBrams) : 1;
  localparam int rowBits  = numParBrams * bramPkg::bramBits;
  localparam int rowBytes = numParBrams * bramPkg::bramBytes;

  localparam logic [serBits-1:0] ownIdx = serBits'(bankIdx);

  logic [rowBytes-1:0] weRowA;  // Byte enables after row select
  logic [rowBytes-1:0] weRowB;

  // Only the selected row takes writes
  assign weRowA = (serIdxA == ownIdx) ? weA : '0;
  assign weRowB = (serIdxB == ownIdx) ? weB : '0;

  for (genvar p = 0; p < numParBrams; p++) begin : gCell
    // Cell 0 sits in the most significant slice
    localparam int bitHi  = rowBits - bramPkg::bramBits * p - 1;
    localparam int byteHi = rowBytes - bramPkg::bramBytes * p - 1;

    tdpBramCell #(
      .wordsPerBram(wordsPerBram)
    ) uCell (
      .A_PS    (A_PS),
      .rstN    (rstN),
      .enA     (enA),
      .enB     (enB),
      .weA     (weRowA[byteHi -: bramPkg::bramBytes]),
      .weB     (weRowB[byteHi -: bramPkg::bramBytes]),
      .addrA   (wordIdxA),
      .addrB   (wordIdxB),
      .wrDataA (wrDataA[bitHi -: bramPkg::bramBits]),
      .wrDataB (wrDataB[bitHi -: bramPkg::bramBits]),
      .rdDataA (rdDataA[bitHi -: bramPkg::bramBits]),
      .rdDataB (rdDataB[bitHi -: bramPkg::bramBits])
    );
  end

endmodule

// File: rtl/bramArray.sv
`timescale 1ns/1ps

module bramArray #(
  parameter int numParBrams  = 3,
  parameter int numSerBrams  = 4,
  parameter int wordsPerBram = 256
) (
  input  logic A_PS,
  input  logic rstN,
  input  logic [((numSerBrams > 1) ? $clog2(numSerBrams) : 1)-1:0]   serIdxA,
  input  logic [((numSerBrams > 1) ? $clog2(numSerBrams) : 1)-1:0]   serIdxB,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] wordIdxA,
  input  logic [((wordsPerBram > 1) ? $clog2(wordsPerBram) : 1)-1:0] wordIdxB,
  input  logic enA,
  input  logic enB,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weA,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weB,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataA,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataB,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataA,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataB
);

  localparam int serBits = (numSerBrams > 1) ? $clog2(numSerBrams) : 1;
  localparam int rowBits = numParBrams * bramPkg::bramBits;

  logic [rowBits-1:0] rowRdA [numSerBrams];  // Read word of every stacked row
  logic [rowBits-1:0] rowRdB [numSerBrams];

  logic [serBits-1:0] serIdxRegA;  // Row of the result in flight
  logic [serBits-1:0] serIdxRegB;

  for (genvar s = 0; s < numSerBrams; s++) begin : gBank
    bramBank #(
      .numParBrams  (numParBrams),
      .numSerBrams  (numSerBrams),
      .wordsPerBram (wordsPerBram),
      .bankIdx      (s)
    ) uBank (
      .A_PS     (A_PS),
      .rstN     (rstN),
      .serIdxA  (serIdxA),
      .serIdxB  (serIdxB),
      .wordIdxA (wordIdxA),
      .wordIdxB (wordIdxB),
      .enA      (enA),
      .enB      (enB),
      .weA      (weA),
      .weB      (weB),
      .wrDataA  (wrDataA),
      .wrDataB  (wrDataB),
      .rdDataA  (rowRdA[s]),
      .rdDataB  (rowRdB[s])
    );
  end

  // Row select follows the cell read latency
  always_ff @(posedge A_PS or negedge rstN) begin
    if (!rstN) begin
      serIdxRegA <= '0;
      serIdxRegB <= '0;
    end else begin
      if (enA) serIdxRegA <= serIdxA;
      if (enB) serIdxRegB <= serIdxB;
    end
  end

  assign rdDataA = rowRdA[serIdxRegA];
  assign rdDataB = rowRdB[serIdxRegB];

endmodule

// File: rtl/tdpBramArray.sv
`timescale 1ns/1ps

module tdpBramArray #(
  parameter int numParBrams  = 3,
  parameter int numSerBrams  = 4,
  parameter int wordsPerBram = 256
) (
  input  logic          A_PS,
  input  logic          rstN,
  input  bramPkg::addrT addrA,
  input  bramPkg::addrT addrB,
  input  logic          enA,
  input  logic          enB,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weA,
  input  logic [numParBrams*bramPkg::bramBytes-1:0] weB,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataA,
  input  logic [numParBrams*bramPkg::bramBits-1:0]  wrDataB,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataA,
  output logic [numParBrams*bramPkg::bramBits-1:0]  rdDataB
);

  localparam int serBits  = (numSerBrams > 1) ? $clog2(numSerBrams) : 1;
  localparam int wordBits = (wordsPerBram > 1) ? $clog2(wordsPerBram) : 1;

  logic [serBits-1:0]  serIdxA;
  logic [serBits-1:0]  serIdxB;
  logic [wordBits-1:0] wordIdxA;
  logic [wordBits-1:0] wordIdxB;

  // Byte address to stacked row and cell word, one decoder per port
  bramAddrDecode #(
    .numParBrams  (numParBrams),
    .numSerBrams  (numSerBrams),
    .wordsPerBram (wordsPerBram)
  ) uDecodeA (
    .addr    (addrA),
    .serIdx  (serIdxA),
    .wordIdx (wordIdxA)
  );

  bramAddrDecode #(
    .numParBrams  (numParBrams),
    .numSerBrams  (numSerBrams),
    .wordsPerBram (wordsPerBram)
  ) uDecodeB (
    .addr    (addrB),
    .serIdx  (serIdxB),
    .wordIdx (wordIdxB)
  );

  bramArray #(
    .numParBrams  (numParBrams),
    .numSerBrams  (numSerBrams),
    .wordsPerBram (wordsPerBram)
  ) uArray (
    .A_PS     (A_PS),
    .rstN     (rstN),
    .serIdxA  (serIdxA),
    .serIdxB  (serIdxB),
    .wordIdxA (wordIdxA),
    .wordIdxB (wordIdxB),
    .enA      (enA),
    .enB      (enB),
    .weA      (weA),
    .weB      (weB),
    .wrDataA  (wrDataA),
    .wrDataB  (wrDataB),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB)
  );

endmodule

// File: bench/tdpBramArray_chk.sv
`timescale 1ns/1ps

module tdpBramArrayChk #(
  parameter int numParBrams  = 3,
  parameter int numSerBrams  = 4,
  parameter int wordsPerBram = 256
) (
  input logic          A_PS,
  input logic          rstN,
  input bramPkg::addrT addrA,
  input bramPkg::addrT addrB,
  input logic          enA,
  input logic          enB,
  input logic [numParBrams*bramPkg::bramBytes-1:0] weA,
  input logic [numParBrams*bramPkg::bramBytes-1:0] weB,
  input logic [numParBrams*bramPkg::bramBits-1:0]  rdDataA,
  input logic [numParBrams*bramPkg::bramBits-1:0]  rdDataB
);

  // One byte past the last row of the whole array
  localparam bramPkg::addrT addrLimit =
    bramPkg::addrT'(numParBrams * bramPkg::bramBytes * numSerBrams * wordsPerBram);

  int assertFails = 0;  // Read by the testbench

  bramPkg::addrT rowA;
  bramPkg::addrT rowB;

  assign rowA = (addrA >> 2) / numParBrams;  // Full row index per port
  assign rowB = (addrB >> 2) / numParBrams;

  rangeA: assert property (@(posedge A_PS) disable iff (!rstN) enA |-> addrA < addrLimit)
    else begin
      assertFails++;
      $error("Port A address out of range");
    end

  rangeB: assert property (@(posedge A_PS) disable iff (!rstN) enB |-> addrB < addrLimit)
    else begin
      assertFails++;
      $error("Port B address out of range");
    end

  // A write against any access to the same row is a collision
  noCollision: assert property (@(posedge A_PS) disable iff (!rstN)
    (enA && enB && ((|weA) || (|weB))) |-> (rowA != rowB))
    else begin
      assertFails++;
      $error("Same-row access on both ports with a write");
    end

  holdA: assert property (@(posedge A_PS) disable iff (!rstN) !enA |=> $stable(rdDataA))
    else begin
      assertFails++;
      $error("Port A read data changed while disabled");
    end

  holdB: assert property (@(posedge A_PS) disable iff (!rstN) !enB |=> $stable(rdDataB))
    else begin
      assertFails++;
      $error("Port B read data changed while disabled");
    end

endmodule

bind tdpBramArray tdpBramArrayChk #(
  .numParBrams  (numParBrams),
  .numSerBrams  (numSerBrams),
  .wordsPerBram (wordsPerBram)
) chk (
  .A_PS    (A_PS),
  .rstN    (rstN),
  .addrA   (addrA),
  .addrB   (addrB),
  .enA     (enA),
  .enB     (enB),
  .weA     (weA),
  .weB     (weB),
  .rdDataA (rdDataA),
  .rdDataB (rdDataB)
);

// File: bench/tdpBramArrayTb.sv
`timescale 1ns/1ps

module tdpBramArrayTb;

  localparam int numParBrams  = 3;
  localparam int numSerBrams  = 4;
  localparam int wordsPerBram = 256;
  localparam int rowW    = numParBrams * bramPkg::bramBits;
  localparam int rowBe   = numParBrams * bramPkg::bramBytes;
  localparam int numRows = numSerBrams * wordsPerBram;

  // Operation counts per test phase in clock cycles
  localparam int resetCycles = 8;
  localparam int dirOps      = 2 * numSerBrams * 4;
  localparam int partOps     = 3 * 8;
  localparam int wfOps       = 8;
  localparam int mapOps      = 5 * 8;
  localparam int poolOps     = 64;
  localparam int randCycles  = 300;
  localparam int numOps = resetCycles + 2 + dirOps + partOps + wfOps + mapOps +
                          poolOps + randCycles + 2;
  localparam int timeoutNs = (numOps + 50) * 4;

  logic          A_PS;
  logic          rstN;
  bramPkg::addrT addrA;
  bramPkg::addrT addrB;
  logic          enA;
  logic          enB;
  logic [rowBe-1:0] weA;
  logic [rowBe-1:0] weB;
  logic [rowW-1:0]  wrDataA;
  logic [rowW-1:0]  wrDataB;
  logic [rowW-1:0]  rdDataA;
  logic [rowW-1:0]  rdDataB;

  logic [rowW-1:0] model [numRows];  // Reference memory with one wide word per row
  logic [rowW-1:0] expQA [$];
  logic [rowW-1:0] expQB [$];
  int              dueQ [$];         // Cycle at which each queued result is due
  logic [rowW-1:0] lastA = '0;
  logic [rowW-1:0] lastB = '0;
  int              cycle = 0;
  integer          seed = 32'hbe13;

  tdpBramArray #(
    .numParBrams  (numParBrams),
    .numSerBrams  (numSerBrams),
    .wordsPerBram (wordsPerBram)
  ) uut (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .addrA   (addrA),
    .addrB   (addrB),
    .enA     (enA),
    .enB     (enB),
    .weA     (weA),
    .weB     (weB),
    .wrDataA (wrDataA),
    .wrDataB (wrDataB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  initial begin
    A_PS = 1'b0;
    forever #2 A_PS = ~A_PS;
  end

  always @(posedge A_PS) cycle <= cycle + 1;

  // Model row of a byte address
  function automatic int rowOf(input bramPkg::addrT addr);
    return (addr >> 2) / numParBrams;
  endfunction

  function automatic bramPkg::addrT rowAddr(input int row);
    return bramPkg::addrT'(row * numParBrams * bramPkg::bramBytes);
  endfunction

  function automatic logic [rowW-1:0] mergeBytes(input logic [rowW-1:0] old,
                                                 input logic [rowW-1:0] data,
                                                 input logic [rowBe-1:0] be);
    logic [rowW-1:0] res;
    res = old;
    for (int i = 0; i < rowBe; i++) begin
      if (be[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic int randBelow(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic logic [rowW-1:0] randWord();
    logic [rowW-1:0] w;
    for (int i = 0; i < numParBrams; i++) w[32*i +: 32] = $random(seed);
    return w;
  endfunction

  function automatic logic [rowBe-1:0] randBe();
    return rowBe'($random(seed));
  endfunction

  // Small pool of rows spread over every stacked row
  function automatic bramPkg::addrT poolAddr(input int idx);
    return rowAddr((idx / 16) * wordsPerBram + idx % 16) + bramPkg::addrT'(randBelow(12));
  endfunction

  task automatic checkRead(input string port, input logic [rowW-1:0] got,
                           input logic [rowW-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: port %s read %h, expected %h", $time, port, got, exp);
      $display("Simulation failed");
      $fatal(1, "Read data mismatch");
    end
  endtask

  task automatic checkZero(input string port, input logic [rowW-1:0] got);
    if (got !== '0) begin
      $display("** Error at %0t ns: port %s read %h after reset, expected zero", $time, port, got);
      $display("Simulation failed");
      $fatal(1, "Reset value mismatch");
    end
  endtask

  // Drives both ports for one cycle and updates the model and expected results
  task automatic step(input logic eA, input bramPkg::addrT aA, input logic [rowBe-1:0] bA,
                      input logic [rowW-1:0] dA, input logic eB, input bramPkg::addrT aB,
                      input logic [rowBe-1:0] bB, input logic [rowW-1:0] dB);
    enA = eA;
    addrA = aA;
    weA = bA;
    wrDataA = dA;
    enB = eB;
    addrB = aB;
    weB = bB;
    wrDataB = dB;
    if (eA) begin
      model[rowOf(aA)] = mergeBytes(model[rowOf(aA)], dA, bA);
      lastA = model[rowOf(aA)];  // Write-first result
    end
    if (eB) begin
      model[rowOf(aB)] = mergeBytes(model[rowOf(aB)], dB, bB);
      lastB = model[rowOf(aB)];
    end
    expQA.push_back(lastA);
    expQB.push_back(lastB);
    dueQ.push_back(cycle + 1);
    @(negedge A_PS);
  endtask

  task automatic accessA(input bramPkg::addrT a, input logic [rowBe-1:0] be,
                         input logic [rowW-1:0] d);
    step(1'b1, a, be, d, 1'b0, '0, '0, '0);
  endtask

  task automatic accessB(input bramPkg::addrT a, input logic [rowBe-1:0] be,
                         input logic [rowW-1:0] d);
    step(1'b0, '0, '0, '0, 1'b1, a, be, d);
  endtask

  // Sampled on the falling edge while the read data is stable
  always @(negedge A_PS) begin
    if (uut.chk.assertFails != 0) begin
      $display("A checker assertion fired during the run");
      $display("Simulation failed");
      $fatal(1, "Assertion failure");
    end else if (dueQ.size() > 0 && dueQ[0] == cycle) begin
      checkRead("A", rdDataA, expQA.pop_front());
      checkRead("B", rdDataB, expQB.pop_front());
      void'(dueQ.pop_front());
    end
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int row;
    int pickA;
    int pickB;
    logic eA;
    logic eB;
    logic [rowBe-1:0] bA;
    logic [rowBe-1:0] bB;
    rstN = 1'b0;
    enA = 1'b0;
    enB = 1'b0;
    addrA = '0;
    addrB = '0;
    weA = '0;
    weB = '0;
    wrDataA = '0;
    wrDataB = '0;
    repeat (resetCycles) @(negedge A_PS);
    rstN = 1'b1;
    @(negedge A_PS);
    checkZero("A", rdDataA);
    checkZero("B", rdDataB);

    for (int s = 0; s < numSerBrams; s++) begin  // Full writes on A into every stacked row
      for (int k = 0; k < 4; k++) accessA(rowAddr(s * wordsPerBram + k * 61), '1, randWord());
    end
    for (int s = 0; s < numSerBrams; s++) begin
      for (int k = 0; k < 4; k++) accessB(rowAddr(s * wordsPerBram + k * 61), '0, '0);
    end

    for (int i = 0; i < 8; i++) begin  // Partial byte writes over a known word
      row = i * 97 + 5;
      accessA(rowAddr(row), '1, randWord());
      accessB(rowAddr(row), randBe(), randWord());
      accessA(rowAddr(row), '0, '0);
    end

    // Both ports write at once and each sees its own merged word
    for (int i = 0; i < 8; i++) begin
      step(1'b1, rowAddr(i * 97 + 5), randBe(), randWord(),
           1'b1, rowAddr((i % 4) * wordsPerBram + (i / 4) * 61), randBe(), randWord());
    end

    for (int i = 0; i < 8; i++) begin  // Aliases inside one row read the same word
      row = numRows - 1 - i * 131;
      accessA(rowAddr(row), '1, randWord());
      for (int k = 0; k < 4; k++) accessB(rowAddr(row) + bramPkg::addrT'(k * 3 + randBelow(3)),
                                          '0, '0);
    end

    for (int i = 0; i < poolOps; i++) begin  // Known contents in every pool row
      accessA(poolAddr(i), '1, randWord());
    end

    for (int n = 0; n < randCycles; n++) begin
      pickA = randBelow(64);
      pickB = (pickA + 1 + randBelow(63)) % 64;  // Never the same row as port A
      eA = (randBelow(4) != 0);
      eB = (randBelow(4) != 0);
      bA = randBelow(2) ? randBe() : '0;
      bB = randBelow(2) ? randBe() : '0;
      step(eA, poolAddr(pickA), bA, randWord(), eB, poolAddr(pickB), bB, randWord());
    end
    step(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
    repeat (2) @(negedge A_PS);

    if (uut.chk.assertFails == 0 && dueQ.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Results left unchecked or checker assertions fired at the end of the run");
      $display("Simulation failed");
      $fatal(1, "End of run check");
    end
  end

endmodule

// File: src.f
rtl/bramPkg.sv
rtl/bramAddrDecode.sv
rtl/tdpBramCell.sv
rtl/bramBank.sv
rtl/bramArray.sv
rtl/tdpBramArray.sv
bench/tdpBramArray_chk.sv
bench/tdpBramArrayTb.sv
